/* Makefile */
# Verilator simulation of the video PPU
TOP := tb_n64_ppu

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -f n64_ppu_top.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* n64_ppu_top.f */
rtl/ppu_pkg.sv
rtl/ppu_pixel_if.sv
rtl/cfg_regs.sv
rtl/vdemux.sv
rtl/color_exec.sv
rtl/vout_result.sv
rtl/n64_ppu_top.sv
testbench/tb_clkgen.sv
testbench/tb_n64_ppu.sv

/* rtl/cfg_regs.sv */
/*
 * Config loader with a four-phase req/ack handshake.
 * The host must hold cfg_data_i stable while cfg_req_i is high.
 */
`timescale 1ns/10ps

module cfg_regs (
  input  logic           VCLK,
  input  logic           nVRST,
  input  logic           cfg_req_i,
  input  ppu_pkg::cfg_t  cfg_data_i,
  output logic           cfg_ack_o,
  output ppu_pkg::cfg_t  cfg_o
);
  import ppu_pkg::*;

  typedef enum logic {
    IDLE,
    ACKED
  } cfg_state_t;

  cfg_state_t state_q;
  cfg_state_t state_d;

  // Handshake sequencing
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // New request seen, word gets loaded on this edge
        if (cfg_req_i) begin
          state_d = ACKED;
        end
      end
      ACKED: begin
        // Wait for the host to release req
        if (!cfg_req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge VCLK) begin
    if (!nVRST) begin
      state_q <= IDLE;
      cfg_o   <= '0;
    end else begin
      state_q <= state_d;
      // Load only on entering ACKED so a held req does not reload
      if (state_q == IDLE && state_d == ACKED) begin
        cfg_o <= cfg_data_i;
      end
    end
  end

  // Ack follows the registered state
  assign cfg_ack_o = (state_q == ACKED);

endmodule

/* rtl/color_exec.sv */
/*
 * Execute stage with gamma correction then optional RGB to YPbPr conversion.
 * Two register stages, gamma and YPbPr enable are sampled as a pixel enters.
 * Reserved gamma code 3 behaves as identity.
 */
`timescale 1ns/10ps

module color_exec (
  input  logic           VCLK,
  input  logic           nVRST,
  input  ppu_pkg::cfg_t  cfg_i,
  ppu_pixel_if.dst       pix_i,
  ppu_pixel_if.src       pix_o
);
  import ppu_pkg::*;

  // Gamma curve on a 7-bit value, widened by repeating the MSB below it
  function automatic color_t gamma_fn(input gamma_sel_t sel, input vin_t x);
    logic [2*VIN_W-1:0] sq;
    vin_t               inv;
    vin_t               y;
    inv = vin_t'(COLOR_MAX - x);
    sq  = '0;
    case (sel)
      GAMMA_IDENT: y = x;
      GAMMA_DARK: begin
        sq = x * x;
        y  = vin_t'(sq / COLOR_MAX);
      end
      GAMMA_BRIGHT: begin
        // Mirror of darken around full scale
        sq = inv * inv;
        y  = vin_t'(COLOR_MAX - sq / COLOR_MAX);
      end
      default: y = x;
    endcase
    return {y, y[VIN_W-1]};
  endfunction

  // One matrix row, floor shift by 8, offset, then clamp to a byte
  function automatic color_t conv_fn(input int kr, input int kg, input int kb,
                                     input int ofs, input color_t r,
                                     input color_t g, input color_t b);
    int acc;
    acc = kr * int'(r) + kg * int'(g) + kb * int'(b);
    acc = (acc >>> 8) + ofs;
    if (acc < 0) begin
      return '0;
    end else if (acc > CHAN_MAX) begin
      return color_t'(CHAN_MAX);
    end
    return color_t'(acc);
  endfunction

  gamma_sel_t gamma_sel;
  assign gamma_sel = cfg_i[CFG_GAMMA_LSB +: GAMMA_W];

  // ===================================================================
  // Stage 1 applies gamma
  // ===================================================================
  logic   s1_valid;
  logic   s1_ypbpr;
  sync_t  s1_sync;
  color_t s1_r;
  color_t s1_g;
  color_t s1_b;

  always_ff @(posedge VCLK) begin
    if (!nVRST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= pix_i.valid;
    end
  end

  always_ff @(posedge VCLK) begin
    if (pix_i.valid) begin
      // Conversion mode rides with the pixel
      s1_ypbpr <= cfg_i[CFG_YPBPR];
      s1_sync  <= pix_i.sync;
      s1_r     <= gamma_fn(gamma_sel, pix_i.ch0[VIN_W-1:0]);
      s1_g     <= gamma_fn(gamma_sel, pix_i.ch1[VIN_W-1:0]);
      s1_b     <= gamma_fn(gamma_sel, pix_i.ch2[VIN_W-1:0]);
    end
  end

  // ===================================================================
  // Stage 2 converts to YPbPr when enabled
  // ===================================================================
  color_t y_c;
  color_t pb_c;
  color_t pr_c;

  assign y_c  = conv_fn(Y_KR, Y_KG, Y_KB, 0, s1_r, s1_g, s1_b);
  assign pb_c = conv_fn(PB_KR, PB_KG, PB_KB, CHROMA_OFFSET, s1_r, s1_g, s1_b);
  assign pr_c = conv_fn(PR_KR, PR_KG, PR_KB, CHROMA_OFFSET, s1_r, s1_g, s1_b);

  always_ff @(posedge VCLK) begin
    if (!nVRST) begin
      pix_o.valid <= 1'b0;
    end else begin
      pix_o.valid <= s1_valid;
    end
  end

  always_ff @(posedge VCLK) begin
    if (s1_valid) begin
      pix_o.sync <= s1_sync;
      if (s1_ypbpr) begin
        // Pr on the red lane, Y on green, Pb on blue
        pix_o.ch0 <= pr_c;
        pix_o.ch1 <= y_c;
        pix_o.ch2 <= pb_c;
      end else begin
        pix_o.ch0 <= s1_r;
        pix_o.ch1 <= s1_g;
        pix_o.ch2 <= s1_b;
      end
    end
  end

endmodule

/* rtl/n64_ppu_top.sv */
/*
 * Video post-processing top level, decode to execute to result.
 * Output lags the blue sample by four edges, at most one pixel per 4 cycles.
 */
`timescale 1ns/10ps

module n64_ppu_top (
  input  logic           VCLK,
  input  logic           nVRST,
  input  logic           nVDSYNC_i,
  input  ppu_pkg::vin_t  VD_i,
  input  logic           cfg_req_i,
  input  ppu_pkg::cfg_t  cfg_data_i,
  output logic           cfg_ack_o,
  input  logic           use_vga_hvsync_i,
  output ppu_pkg::vout_t VD_o,
  output logic [1:0]     nCSYNC_o,
  output logic           nVSYNC_or_F2_o,
  output logic           nHSYNC_or_F1_o
);
  import ppu_pkg::*;

  // Active configuration shared by execute and result
  cfg_t cfg_w;

  // Pixel links between stages
  ppu_pixel_if pix_dec ();
  ppu_pixel_if pix_exe ();

  // ===================================================================
  // Configuration
  // ===================================================================
  cfg_regs u_cfg_regs (
    .VCLK       (VCLK),
    .nVRST      (nVRST),
    .cfg_req_i  (cfg_req_i),
    .cfg_data_i (cfg_data_i),
    .cfg_ack_o  (cfg_ack_o),
    .cfg_o      (cfg_w)
  );

  // ===================================================================
  // Pipeline
  // ===================================================================
  vdemux u_vdemux (
    .VCLK      (VCLK),
    .nVRST     (nVRST),
    .nVDSYNC_i (nVDSYNC_i),
    .VD_i      (VD_i),
    .pix_o     (pix_dec.src)
  );

  color_exec u_color_exec (
    .VCLK  (VCLK),
    .nVRST (nVRST),
    .cfg_i (cfg_w),
    .pix_i (pix_dec.dst),
    .pix_o (pix_exe.src)
  );

  vout_result u_vout_result (
    .VCLK             (VCLK),
    .nVRST            (nVRST),
    .cfg_i            (cfg_w),
    .use_vga_hvsync_i (use_vga_hvsync_i),
    .pix_i            (pix_exe.dst),
    .VD_o             (VD_o),
    .nCSYNC_o         (nCSYNC_o),
    .nVSYNC_or_F2_o   (nVSYNC_or_F2_o),
    .nHSYNC_or_F1_o   (nHSYNC_or_F1_o)
  );

endmodule

/* rtl/ppu_pixel_if.sv */
/*
 * One demultiplexed pixel plus its sync bits between pipeline stages.
 * valid is a single-cycle strobe per pixel and there is no back-pressure.
 */
`timescale 1ns/10ps

interface ppu_pixel_if;
  import ppu_pkg::*;

  // Pixel strobe, one cycle per pixel
  logic   valid;
  // Sync nibble travelling with the pixel
  sync_t  sync;
  // Channels ordered R|Pr, G|Y, B|Pb
  color_t ch0;
  color_t ch1;
  color_t ch2;

  // Producing stage drives everything
  modport src (
    output valid, sync, ch0, ch1, ch2
  );

  // Consuming stage only samples
  modport dst (
    input valid, sync, ch0, ch1, ch2
  );

endinterface

/* rtl/ppu_pkg.sv */
/*
 * Shared widths, vector types and config field positions of the video PPU.
 * Colors enter as 7-bit values and are widened to 8 bits in the execute stage.
 * Config bits 15:7 are reserved and ignored by the datapath.
 */
package ppu_pkg;

  // ===================================================================
  // Widths
  // ===================================================================
  localparam int VIN_W    = 7;
  localparam int COLOR_W  = 8;
  localparam int SYNC_W   = 4;
  localparam int CFG_W    = 16;
  localparam int GAMMA_W  = 2;
  localparam int FILTER_W = 2;
  localparam int VOUT_W   = 3 * COLOR_W;

  // Raw multiplexed video byte from the console
  typedef logic [VIN_W-1:0]    vin_t;
  // One color channel, 7-bit values sit in the low bits until widened
  typedef logic [COLOR_W-1:0]  color_t;
  // DAC word as {ch0, ch1, ch2}, i.e. {R|Pr, G|Y, B|Pb}
  typedef logic [VOUT_W-1:0]   vout_t;
  // Active low sync group {nVSYNC, nCLAMP, nHSYNC, nCSYNC}
  typedef logic [SYNC_W-1:0]   sync_t;
  typedef logic [CFG_W-1:0]    cfg_t;
  typedef logic [GAMMA_W-1:0]  gamma_sel_t;
  // Bit 1 goes to F1, bit 0 goes to F2
  typedef logic [FILTER_W-1:0] filter_t;

  // Sync bit positions inside sync_t
  localparam int SYNC_NVSYNC = 3;
  localparam int SYNC_NHSYNC = 1;
  localparam int SYNC_NCSYNC = 0;

  // ===================================================================
  // Config word fields
  // ===================================================================
  localparam int CFG_GAMMA_LSB  = 0;
  localparam int CFG_YPBPR      = 2;
  localparam int CFG_RGSB       = 3;
  localparam int CFG_FILTER_LSB = 4;
  localparam int CFG_HD_HINT    = 6;

  // Gamma curve codes, code 3 is reserved and behaves as identity
  localparam gamma_sel_t GAMMA_IDENT  = 2'd0;
  localparam gamma_sel_t GAMMA_DARK   = 2'd1;
  localparam gamma_sel_t GAMMA_BRIGHT = 2'd2;

  // Filter setting codes as written by the host
  localparam filter_t FILTER_AUTO   = 2'd0;
  localparam filter_t FILTER_9M5    = 2'd1;
  localparam filter_t FILTER_18M    = 2'd2;
  localparam filter_t FILTER_BYPASS = 2'd3;

  // ===================================================================
  // Color math constants
  // ===================================================================
  localparam int unsigned COLOR_MAX = 127;
  localparam int          CHAN_MAX  = 2**COLOR_W - 1;

  // BT.601 style rows scaled by 256
  localparam int Y_KR  = 77;
  localparam int Y_KG  = 150;
  localparam int Y_KB  = 29;
  localparam int PB_KR = -43;
  localparam int PB_KG = -85;
  localparam int PB_KB = 128;
  localparam int PR_KR = 128;
  localparam int PR_KG = -107;
  localparam int PR_KB = -21;
  localparam int CHROMA_OFFSET = 128;

endpackage

/* rtl/vdemux.sv */
/*
 * Decode stage for the multiplexed video bus.
 * Expects sync, R, G, B on four consecutive edges after nVDSYNC low.
 * An early nVDSYNC low drops the partial pixel.
 */
`timescale 1ns/10ps

module vdemux (
  input  logic            VCLK,
  input  logic            nVRST,
  input  logic            nVDSYNC_i,
  input  ppu_pkg::vin_t   VD_i,
  ppu_pixel_if.src        pix_o
);
  import ppu_pkg::*;

  // Phase 0 is idle, 1..3 expect R, G and B
  logic [1:0] phase_q;
  // Blue was captured on the previous edge
  logic       done_q;

  // Holding registers for the pixel being collected
  sync_t      sync_q;
  vin_t       red_q;
  vin_t       grn_q;
  vin_t       blu_q;

  // ===================================================================
  // Phase tracking
  // ===================================================================
  always_ff @(posedge VCLK) begin
    if (!nVRST) begin
      phase_q <= 2'd0;
      done_q  <= 1'b0;
    end else if (!nVDSYNC_i) begin
      // Sync byte restarts the sequence
      phase_q <= 2'd1;
      done_q  <= 1'b0;
    end else begin
      done_q <= (phase_q == 2'd3);
      if (phase_q != 2'd0) begin
        phase_q <= (phase_q == 2'd3) ? 2'd0 : phase_q + 2'd1;
      end
    end
  end

  // Byte capture
  always_ff @(posedge VCLK) begin
    if (!nVDSYNC_i) begin
      sync_q <= VD_i[SYNC_W-1:0];
    end else begin
      case (phase_q)
        2'd1:    red_q <= VD_i;
        2'd2:    grn_q <= VD_i;
        2'd3:    blu_q <= VD_i;
        default: ;
      endcase
    end
  end

  // ===================================================================
  // Pixel output, one cycle after blue
  // ===================================================================
  always_ff @(posedge VCLK) begin
    if (!nVRST) begin
      pix_o.valid <= 1'b0;
    end else begin
      pix_o.valid <= done_q;
    end
  end

  // Payload holds between pixels
  always_ff @(posedge VCLK) begin
    if (done_q) begin
      pix_o.sync <= sync_q;
      pix_o.ch0  <= {1'b0, red_q};
      pix_o.ch1  <= {1'b0, grn_q};
      pix_o.ch2  <= {1'b0, blu_q};
    end
  end

endmodule

/* rtl/vout_result.sv */
/*
 * Result stage driving the DAC bus, two composite syncs and the shared pins.
 * nCSYNC_o[0] is held low unless RGsB or YPbPr is enabled.
 * Filter bits follow the config every cycle, not per pixel.
 */
`timescale 1ns/10ps

module vout_result (
  input  logic           VCLK,
  input  logic           nVRST,
  input  ppu_pkg::cfg_t  cfg_i,
  input  logic           use_vga_hvsync_i,
  ppu_pixel_if.dst       pix_i,
  output ppu_pkg::vout_t VD_o,
  output logic [1:0]     nCSYNC_o,
  output logic           nVSYNC_or_F2_o,
  output logic           nHSYNC_or_F1_o
);
  import ppu_pkg::*;

  sync_t   sync_q;
  filter_t filt_q;
  filter_t filt_set;
  logic    csync_en;

  // Color and sync update once per pixel
  always_ff @(posedge VCLK) begin
    if (!nVRST) begin
      VD_o   <= '0;
      sync_q <= '1;
    end else if (pix_i.valid) begin
      VD_o   <= {pix_i.ch0, pix_i.ch1, pix_i.ch2};
      sync_q <= pix_i.sync;
    end
  end

  // ===================================================================
  // Video filter select
  // ===================================================================
  assign filt_set = cfg_i[CFG_FILTER_LSB +: FILTER_W];

  always_ff @(posedge VCLK) begin
    if (!nVRST) begin
      filt_q <= '0;
    end else begin
      case (filt_set)
        FILTER_BYPASS: filt_q <= 2'b11;
        FILTER_18M:    filt_q <= 2'b01;
        FILTER_9M5:    filt_q <= 2'b00;
        // Auto picks 18 MHz only when the host hints at a high-rate mode
        FILTER_AUTO:   filt_q <= cfg_i[CFG_HD_HINT] ? 2'b01 : 2'b00;
        default:       filt_q <= 2'b00;
      endcase
    end
  end

  // ===================================================================
  // Sync outputs
  // ===================================================================
  assign csync_en = cfg_i[CFG_RGSB] | cfg_i[CFG_YPBPR];

  // Upper pin always carries csync, lower one feeds sync-on-green
  assign nCSYNC_o[1] = sync_q[SYNC_NCSYNC];
  assign nCSYNC_o[0] = csync_en ? sync_q[SYNC_NCSYNC] : 1'b0;

  // Shared pins are VGA syncs or filter bits
  assign nVSYNC_or_F2_o = use_vga_hvsync_i ? sync_q[SYNC_NVSYNC] : filt_q[0];
  assign nHSYNC_or_F1_o = use_vga_hvsync_i ? sync_q[SYNC_NHSYNC] : filt_q[1];

endmodule

/* testbench/tb_clkgen.sv */
/*
 * Clock and reset source for the testbench, 40 ns period.
 * Reset is held low for 5 rising edges and released on a falling edge.
 */
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Synchronous reset, released away from the active edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* testbench/tb_n64_ppu.sv */
/*
 * Self-checking testbench for the video PPU, random pixels from a fixed seed.
 * Each pixel is checked after the seventh edge past its sync byte.
 * Config is only changed while no pixel is in flight.
 */
`timescale 1ns/10ps

module tb_n64_ppu;
  import ppu_pkg::*;

  // ===================================================================
  // Run length and cycle budget
  // ===================================================================
  localparam int RGB_PIX    = 200;
  localparam int YUV_PIX    = 200;
  localparam int SYNC_PIX   = 25;
  localparam int PIN_PIX    = 10;
  localparam int RAND_LOADS = 8;
  localparam int PASSES     = 4 + 1 + 4 + 1 + 8;
  localparam int CFG_LOADS  = RAND_LOADS + PASSES;
  localparam int TOTAL_PIX  = 4 * RGB_PIX + YUV_PIX + 5 * SYNC_PIX + 8 * PIN_PIX;
  // Handshake is two edges plus up to three stall cycles
  localparam int CFG_CYC    = 6;
  localparam int DRAIN_CYC  = 10;
  localparam int CYCLE_LIMIT = 5 + TOTAL_PIX * 4 + CFG_LOADS * CFG_CYC
                               + PASSES * DRAIN_CYC + 100;

  logic       vclk;
  logic       nvrst;
  logic       nvdsync;
  vin_t       vd_in;
  logic       cfg_req;
  cfg_t       cfg_data;
  logic       cfg_ack;
  logic       use_vga;
  vout_t      vd_out;
  logic [1:0] ncsync;
  logic       pin_f2;
  logic       pin_f1;

  int    cyc = 0;
  string test_name;
  cfg_t  cur_cfg;

  // Expected results in pixel order with the cycle they are due
  vout_t exp_vout_q[$];
  sync_t exp_sync_q[$];
  int    due_q[$];

  tb_clkgen u_tb_clkgen (
    .clk_o   (vclk),
    .rst_n_o (nvrst)
  );

  n64_ppu_top u_n64_ppu_top (
    .VCLK             (vclk),
    .nVRST            (nvrst),
    .nVDSYNC_i        (nvdsync),
    .VD_i             (vd_in),
    .cfg_req_i        (cfg_req),
    .cfg_data_i       (cfg_data),
    .cfg_ack_o        (cfg_ack),
    .use_vga_hvsync_i (use_vga),
    .VD_o             (vd_out),
    .nCSYNC_o         (ncsync),
    .nVSYNC_or_F2_o   (pin_f2),
    .nHSYNC_or_F1_o   (pin_f1)
  );

  // ===================================================================
  // Reference model
  // ===================================================================
  // Gamma on a 7-bit value then MSB copied into the new LSB
  function automatic color_t apply_gamma(gamma_sel_t sel, vin_t x);
    int xi;
    int v;
    xi = int'(x);
    if (sel == 2'd1) begin
      v = (xi * xi) / 127;
    end else if (sel == 2'd2) begin
      v = 127 - ((127 - xi) * (127 - xi)) / 127;
    end else begin
      v = xi;
    end
    return {v[6:0], v[6]};
  endfunction

  function automatic color_t clamp_byte(int v);
    if (v < 0) begin
      return 8'd0;
    end
    if (v > 255) begin
      return 8'd255;
    end
    return color_t'(v);
  endfunction

  // DAC word is {R, G, B} or {Pr, Y, Pb}
  function automatic vout_t model_vout(cfg_t cfg, vin_t r, vin_t g, vin_t b);
    gamma_sel_t sel;
    int ri;
    int gi;
    int bi;
    int y;
    int pb;
    int pr;
    sel = cfg[CFG_GAMMA_LSB +: 2];
    ri  = int'(apply_gamma(sel, r));
    gi  = int'(apply_gamma(sel, g));
    bi  = int'(apply_gamma(sel, b));
    if (!cfg[CFG_YPBPR]) begin
      return {color_t'(ri), color_t'(gi), color_t'(bi)};
    end
    // Signed shift gives the floor for negative chroma sums
    y  = (Y_KR * ri + Y_KG * gi + Y_KB * bi) >>> 8;
    pb = ((PB_KR * ri + PB_KG * gi + PB_KB * bi) >>> 8) + CHROMA_OFFSET;
    pr = ((PR_KR * ri + PR_KG * gi + PR_KB * bi) >>> 8) + CHROMA_OFFSET;
    return {clamp_byte(pr), clamp_byte(y), clamp_byte(pb)};
  endfunction

  // Packed as {nCSYNC_o[1], nCSYNC_o[0], F1 pin, F2 pin}
  function automatic sync_t model_sync(cfg_t cfg, logic vga, sync_t s);
    filter_t f;
    logic    csync_lo;
    case (cfg[CFG_FILTER_LSB +: 2])
      2'd3:    f = 2'b11;
      2'd2:    f = 2'b01;
      2'd1:    f = 2'b00;
      default: f = cfg[CFG_HD_HINT] ? 2'b01 : 2'b00;
    endcase
    csync_lo = (cfg[CFG_RGSB] | cfg[CFG_YPBPR]) ? s[0] : 1'b0;
    if (vga) begin
      return {s[0], csync_lo, s[1], s[3]};
    end
    return {s[0], csync_lo, f[1], f[0]};
  endfunction

  // ===================================================================
  // Checks
  // ===================================================================
  task automatic stop_on_error();
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_vout(string name, vout_t exp, vout_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: VD_o expected %06h, actual %06h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_sync(string name, sync_t exp, sync_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: sync pins expected %04b, actual %04b", name, exp, act);
      stop_on_error();
    end
  endtask

  // Advance to the next falling edge and check any pixel due now
  task automatic next_cycle();
    vout_t ev;
    sync_t es;
    @(negedge vclk);
    if (due_q.size() != 0 && due_q[0] == cyc) begin
      ev = exp_vout_q.pop_front();
      es = exp_sync_q.pop_front();
      void'(due_q.pop_front());
      check_vout(test_name, ev, vd_out);
      check_sync(test_name, es, {ncsync, pin_f1, pin_f2});
    end
  endtask

  task automatic drain();
    while (due_q.size() != 0) begin
      next_cycle();
    end
  endtask

  // ===================================================================
  // Stimulus
  // ===================================================================
  // Sync byte then R, G, B on four falling edges
  task automatic send_pixel();
    sync_t s;
    vin_t  r;
    vin_t  g;
    vin_t  b;
    s = sync_t'($urandom);
    r = vin_t'($urandom);
    g = vin_t'($urandom);
    b = vin_t'($urandom);
    exp_vout_q.push_back(model_vout(cur_cfg, r, g, b));
    exp_sync_q.push_back(model_sync(cur_cfg, use_vga, s));
    // Sync byte is sampled on the coming edge and the output settles 7 edges later
    due_q.push_back(cyc + 8);
    nvdsync = 1'b0;
    vd_in   = {3'($urandom), s};
    next_cycle();
    nvdsync = 1'b1;
    vd_in   = r;
    next_cycle();
    vd_in   = g;
    next_cycle();
    vd_in   = b;
    next_cycle();
  endtask

  // Four-phase load with a random host stall while ack is high
  task automatic load_cfg(cfg_t w);
    int stall;
    if (cfg_ack) begin
      $display("config handshake: ack was already high before req");
      stop_on_error();
    end
    cfg_data = w;
    cfg_req  = 1'b1;
    next_cycle();
    if (!cfg_ack) begin
      $display("config handshake: ack did not rise on the edge after req");
      stop_on_error();
    end
    cur_cfg = w;
    stall = $urandom_range(0, 3);
    repeat (stall) begin
      next_cycle();
      if (!cfg_ack) begin
        $display("config handshake: ack dropped while req was still high");
        stop_on_error();
      end
    end
    cfg_req = 1'b0;
    next_cycle();
    if (cfg_ack) begin
      $display("config handshake: ack did not fall after req was released");
      stop_on_error();
    end
  endtask

  task automatic run_pass(string name, cfg_t c, logic vga, int npix);
    drain();
    test_name = name;
    use_vga   = vga;
    load_cfg(c);
    repeat (npix) begin
      send_pixel();
    end
    drain();
  endtask

  // Cycle counter doubles as the run limit
  always @(posedge vclk) begin
    cyc <= cyc + 1;
    if (cyc > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  // ===================================================================
  // Test sequence
  // ===================================================================
  initial begin
    cfg_t c;
    void'($urandom(2));
    nvdsync   = 1'b1;
    vd_in     = '0;
    cfg_req   = 1'b0;
    cfg_data  = '0;
    use_vga   = 1'b1;
    cur_cfg   = '0;
    test_name = "reset";

    // Reset values with csync gated low by the empty config
    @(posedge nvrst);
    check_vout(test_name, '0, vd_out);
    check_sync(test_name, model_sync('0, 1'b1, '1), {ncsync, pin_f1, pin_f2});
    if (cfg_ack !== 1'b0) begin
      $display("reset: cfg_ack_o is not low after reset");
      stop_on_error();
    end

    // Random loads where the pins must follow the new config at once
    // No pixel has been sent yet so the sync group still holds its reset value
    test_name = "cfg_handshake";
    repeat (RAND_LOADS) begin
      use_vga = 1'($urandom);
      c = cfg_t'($urandom);
      load_cfg(c);
      check_sync(test_name, model_sync(c, use_vga, '1), {ncsync, pin_f1, pin_f2});
    end

    // RGB path with one pass per gamma code
    for (int g = 0; g < 4; g++) begin
      c = cfg_t'($urandom);
      c[CFG_GAMMA_LSB +: 2] = gamma_sel_t'(g);
      c[CFG_YPBPR] = 1'b0;
      run_pass($sformatf("rgb_gamma%0d", g), c, 1'($urandom), RGB_PIX);
    end

    // YPbPr conversion
    c = cfg_t'($urandom);
    c[CFG_YPBPR] = 1'b1;
    run_pass("ypbpr", c, 1'($urandom), YUV_PIX);

    // Composite sync gating over RGsB and YPbPr
    for (int m = 0; m < 4; m++) begin
      c = cfg_t'($urandom);
      c[CFG_RGSB]  = m[0];
      c[CFG_YPBPR] = m[1];
      run_pass($sformatf("csync_mode%0d", m), c, 1'($urandom), SYNC_PIX);
    end

    // Shared pins as VGA syncs and then as filter bits
    run_pass("pins_vga", cfg_t'($urandom), 1'b1, SYNC_PIX);
    for (int f = 0; f < 4; f++) begin
      for (int h = 0; h < 2; h++) begin
        c = cfg_t'($urandom);
        c[CFG_FILTER_LSB +: 2] = filter_t'(f);
        c[CFG_HD_HINT] = h[0];
        run_pass($sformatf("pins_filter%0d_hint%0d", f, h), c, 1'b0, PIN_PIX);
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule
